// ==== source/adv_pkg.sv ====
// Video decoder setup package with bus timing, register values, transfer script and state types
`default_nettype none

package adv_pkg;

  //////////////////////////////////////////////////
  // Bus timing
  //////////////////////////////////////////////////

  // clk cycles per bus tick as two 27-cycle half periods
  localparam int TICK_DIVIDE = 54;
  localparam int DIV_W = $clog2(TICK_DIVIDE);

  // Bus reset stretch after the system reset falls
  localparam int RESET_HOLD = 100;
  localparam int HOLD_W = $clog2(RESET_HOLD + 1);
  localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(RESET_HOLD);

  //////////////////////////////////////////////////
  // Decoder chip registers
  //////////////////////////////////////////////////

  // Slave write and read addresses
  localparam logic [7:0] DEV_WRITE_ADDR = 8'h8A;
  localparam logic [7:0] DEV_READ_ADDR  = 8'h8B;

  // Registers 0 to F written as one auto-increment burst
  // 0 composite in with autodetect   1 auto startup   2 peaking 0dB
  // 3 10-bit CCIR656 out         4 BT656-3        5 chroma blanked in VBI
  // 6 reserved and zero          7 FIFO margin    8..B contrast sat bright hue
  // C..D default Y/Cr/Cb         E no decimation  F full operation
  localparam logic [7:0] REG_VALUES [16] = '{
    8'h00, 8'h80, 8'h04, 8'h00, 8'h0C, 8'h40, 8'h00, 8'h90,
    8'h80, 8'h8C, 8'h00, 8'h00, 8'h30, 8'h88, 8'h00, 8'h00
  };

  // Register 33 sets peak white per field and color kill
  localparam logic [7:0] REG33_SUBADDR = 8'h33;
  localparam logic [7:0] REG33_VALUE   = 8'hE3;

  // Input select bits of register 0 are all set for s-video
  localparam logic [7:0] SOURCE_MASK = 8'h07;

  //////////////////////////////////////////////////
  // Transfer script
  //////////////////////////////////////////////////

  // Each entry is {last of transaction, byte}
  localparam int SCRIPT_LEN = 25;
  localparam int SCRIPT_IDX_W = $clog2(SCRIPT_LEN);
  localparam int REG0_INDEX = 2;

  localparam logic [8:0] INIT_SCRIPT [SCRIPT_LEN] = '{
    {1'b0, DEV_WRITE_ADDR}, {1'b0, 8'h00},
    {1'b0, REG_VALUES[0]},  {1'b0, REG_VALUES[1]},  {1'b0, REG_VALUES[2]},
    {1'b0, REG_VALUES[3]},  {1'b0, REG_VALUES[4]},  {1'b0, REG_VALUES[5]},
    {1'b0, REG_VALUES[6]},  {1'b0, REG_VALUES[7]},  {1'b0, REG_VALUES[8]},
    {1'b0, REG_VALUES[9]},  {1'b0, REG_VALUES[10]}, {1'b0, REG_VALUES[11]},
    {1'b0, REG_VALUES[12]}, {1'b0, REG_VALUES[13]}, {1'b0, REG_VALUES[14]},
    {1'b1, REG_VALUES[15]},
    // Register 33 write
    {1'b0, DEV_WRITE_ADDR}, {1'b0, REG33_SUBADDR}, {1'b1, REG33_VALUE},
    // Leave the subaddress pointer on 33
    {1'b0, DEV_WRITE_ADDR}, {1'b1, REG33_SUBADDR},
    // Read address with a dummy byte
    {1'b0, DEV_READ_ADDR},  {1'b1, 8'hFF}
  };

  //////////////////////////////////////////////////
  // State types
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    SEQ_HOLD_RESET, SEQ_RESET_WAIT, SEQ_RELEASE, SEQ_SEND,
    SEQ_DRAIN, SEQ_WATCH, SEQ_RW_SEND, SEQ_RW_DRAIN
  } seq_state_t;

  typedef enum logic [2:0] {
    TX_IDLE, TX_START, TX_BITS, TX_ACK, TX_STOP
  } tx_state_t;

endpackage

`default_nettype wire

// ==== source/i2c_rate_gen.sv ====
// Bus rate generator that makes the tick enable and the stretched bus reset
`timescale 1ns/1ps
`default_nettype none

module i2c_rate_gen (
  input  logic clk,
  input  logic reset,
  output logic tick,
  output logic bus_reset
);

  logic [adv_pkg::DIV_W-1:0]  div_count;
  logic [adv_pkg::HOLD_W-1:0] hold_count;

  // Free-running divider, wraps after TICK_DIVIDE cycles
  always_ff @(posedge clk)
  begin
    if (reset)
      div_count <= '0;
    else if (tick)
      div_count <= '0;
    else
      div_count <= div_count + 1'b1;
  end

  // One clk wide pulse on the last count
  assign tick = (int'(div_count) == adv_pkg::TICK_DIVIDE - 1);

  // Hold counter, reloaded while reset is high
  // and then counting down to zero
  always_ff @(posedge clk)
  begin
    if (reset)
      hold_count <= adv_pkg::HOLD_LOAD;
    else if (hold_count != '0)
      hold_count <= hold_count - 1'b1;
  end

  // Bus side stays in reset until the hold runs out
  assign bus_reset = (hold_count != '0);

endmodule

`default_nettype wire

// ==== source/i2c_byte_tx.sv ====
// Two-wire bus byte transmitter with start, eight data bits, acknowledge slot, chaining and stop
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_tx (
  input  logic       clk,
  input  logic       reset,
  input  logic       tick,
  input  logic [7:0] data,
  input  logic       load,
  output logic       ack,
  output logic       idle,
  output logic       scl,
  output logic       sda
);

  adv_pkg::tx_state_t state;
  logic [1:0] phase;
  logic [2:0] bit_cnt;
  logic [7:0] shift_reg;
  logic       take;

  // New byte taken from idle or at the end of an acknowledge slot
  assign take = load && (state == adv_pkg::TX_IDLE ||
                         (state == adv_pkg::TX_ACK && phase == 2'd3));

  assign idle = (state == adv_pkg::TX_IDLE);

  // Byte shifter, MSB goes out first
  always_ff @(posedge clk)
  begin
    if (tick && take)
      shift_reg <= data;
    else if (tick && state == adv_pkg::TX_BITS && phase == 2'd3)
      shift_reg <= {shift_reg[6:0], 1'b0};
  end

  //////////////////////////////////////////////////
  // Bus FSM, sda is a level where 1 means released
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state   <= adv_pkg::TX_IDLE;
      phase   <= '0;
      bit_cnt <= '0;
      ack     <= 1'b0;
      scl     <= 1'b1;
      sda     <= 1'b1;
    end
    else if (tick)
    begin
      // ack is a single tick pulse
      ack <= take;
      phase <= phase + 1'b1;
      case (state)
        adv_pkg::TX_IDLE:
        begin
          // Releasing sda here also finishes a stop
          scl   <= 1'b1;
          sda   <= 1'b1;
          phase <= '0;
          if (take)
            state <= adv_pkg::TX_START;
        end
        adv_pkg::TX_START:
        begin
          // sda falls while scl is high, then scl drops
          if (phase == 2'd0)
            sda <= 1'b0;
          else
          begin
            scl     <= 1'b0;
            phase   <= '0;
            bit_cnt <= '0;
            state   <= adv_pkg::TX_BITS;
          end
        end
        adv_pkg::TX_BITS:
        begin
          // Set data, raise scl, hold, lower scl
          if (phase == 2'd0)
            sda <= shift_reg[7];
          else if (phase == 2'd1)
            scl <= 1'b1;
          else if (phase == 2'd3)
          begin
            scl     <= 1'b0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
              state <= adv_pkg::TX_ACK;
          end
        end
        adv_pkg::TX_ACK:
        begin
          // Slave's bit is not sampled
          if (phase == 2'd0)
            sda <= 1'b1;
          else if (phase == 2'd1)
            scl <= 1'b1;
          else if (phase == 2'd3)
          begin
            scl <= 1'b0;
            // Chain straight into the next byte when load is still up
            state <= take ? adv_pkg::TX_BITS : adv_pkg::TX_STOP;
          end
        end
        adv_pkg::TX_STOP:
        begin
          // Pull sda low under scl low, then raise scl
          if (phase == 2'd0)
            sda <= 1'b0;
          else
          begin
            scl   <= 1'b1;
            phase <= '0;
            state <= adv_pkg::TX_IDLE;
          end
        end
        default:
          state <= adv_pkg::TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/adv_config_seq.sv ====
// Decoder setup sequencer that resets the chip, runs the register script and tracks the input select
`timescale 1ns/1ps
`default_nettype none

module adv_config_seq (
  input  logic       clk,
  input  logic       reset,
  input  logic       tick,
  input  logic       source,
  input  logic       tx_ack,
  input  logic       tx_idle,
  output logic [7:0] tx_data,
  output logic       tx_load,
  output logic       tv_in_reset_b
);

  adv_pkg::seq_state_t state;
  logic [adv_pkg::SCRIPT_IDX_W-1:0] byte_idx;
  logic       old_source;
  logic [8:0] script_entry;
  logic [7:0] send_byte;
  logic       entry_last;
  logic       at_reg0;
  logic       next_reg0;

  //////////////////////////////////////////////////
  // Script lookup
  //////////////////////////////////////////////////

  always_comb
  begin
    script_entry = adv_pkg::INIT_SCRIPT[byte_idx];
    entry_last   = script_entry[8];
    at_reg0      = (int'(byte_idx) == adv_pkg::REG0_INDEX);
    next_reg0    = (int'(byte_idx) + 1 == adv_pkg::REG0_INDEX);
    send_byte    = script_entry[7:0];
    // s-video sets the input select bits of register 0
    if (at_reg0 && old_source)
      send_byte = send_byte | adv_pkg::SOURCE_MASK;
  end

  // Byte held steady until the transmitter acks it
  always_ff @(posedge clk)
  begin
    if (tick && (state == adv_pkg::SEQ_SEND || state == adv_pkg::SEQ_RW_SEND))
      tx_data <= send_byte;
  end

  //////////////////////////////////////////////////
  // Sequencer FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state         <= adv_pkg::SEQ_HOLD_RESET;
      byte_idx      <= '0;
      old_source    <= 1'b0;
      tx_load       <= 1'b0;
      tv_in_reset_b <= 1'b0;
    end
    else if (tick)
    begin
      case (state)
        adv_pkg::SEQ_HOLD_RESET:
        begin
          // Chip held in reset for two ticks
          tx_load       <= 1'b0;
          tv_in_reset_b <= 1'b0;
          state         <= adv_pkg::SEQ_RESET_WAIT;
        end
        adv_pkg::SEQ_RESET_WAIT:
          state <= adv_pkg::SEQ_RELEASE;
        adv_pkg::SEQ_RELEASE:
        begin
          tv_in_reset_b <= 1'b1;
          state         <= adv_pkg::SEQ_SEND;
        end
        adv_pkg::SEQ_SEND:
        begin
          tx_load <= 1'b1;
          if (tx_ack)
          begin
            if (entry_last)
            begin
              // Stop follows this byte
              tx_load <= 1'b0;
              state   <= adv_pkg::SEQ_DRAIN;
            end
            else
            begin
              byte_idx <= byte_idx + 1'b1;
              // Freeze the select value written into register 0
              if (next_reg0)
                old_source <= source;
            end
          end
        end
        adv_pkg::SEQ_DRAIN:
        begin
          // Wait for the stop, then next transaction or done
          if (tx_idle)
          begin
            if (int'(byte_idx) == adv_pkg::SCRIPT_LEN - 1)
              state <= adv_pkg::SEQ_WATCH;
            else
            begin
              byte_idx <= byte_idx + 1'b1;
              state    <= adv_pkg::SEQ_SEND;
            end
          end
        end
        adv_pkg::SEQ_WATCH:
        begin
          // Rewrite register 0 on a select change
          if (source != old_source)
          begin
            old_source <= source;
            byte_idx   <= '0;
            state      <= adv_pkg::SEQ_RW_SEND;
          end
        end
        adv_pkg::SEQ_RW_SEND:
        begin
          // Replays the first three script bytes
          tx_load <= 1'b1;
          if (tx_ack)
          begin
            if (at_reg0)
            begin
              tx_load <= 1'b0;
              state   <= adv_pkg::SEQ_RW_DRAIN;
            end
            else
              byte_idx <= byte_idx + 1'b1;
          end
        end
        adv_pkg::SEQ_RW_DRAIN:
        begin
          if (tx_idle)
            state <= adv_pkg::SEQ_WATCH;
        end
        default:
          state <= adv_pkg::SEQ_HOLD_RESET;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/adv_config_top.sv ====
// Decoder setup top level joining the rate generator, the sequencer and the byte transmitter
`timescale 1ns/1ps
`default_nettype none

module adv_config_top (
  input  logic clk,
  input  logic reset,
  input  logic source,
  output logic tv_in_reset_b,
  output logic scl,
  output logic sda
);

  // Rate generator outputs
  logic       tick;
  logic       bus_reset;

  // Sequencer to transmitter handshake
  logic [7:0] tx_data;
  logic       tx_load;
  logic       tx_ack;
  logic       tx_idle;

  i2c_rate_gen u_rate_gen (
    .clk       (clk),
    .reset     (reset),
    .tick      (tick),
    .bus_reset (bus_reset)
  );

  adv_config_seq u_seq (
    .clk           (clk),
    .reset         (bus_reset),
    .tick          (tick),
    .source        (source),
    .tx_ack        (tx_ack),
    .tx_idle       (tx_idle),
    .tx_data       (tx_data),
    .tx_load       (tx_load),
    .tv_in_reset_b (tv_in_reset_b)
  );

  i2c_byte_tx u_byte_tx (
    .clk   (clk),
    .reset (bus_reset),
    .tick  (tick),
    .data  (tx_data),
    .load  (tx_load),
    .ack   (tx_ack),
    .idle  (tx_idle),
    .scl   (scl),
    .sda   (sda)
  );

endmodule

`default_nettype wire

// ==== bench/i2c_bus_checker.sv ====
// Two-wire bus monitor that decodes transfers and checks them against the setup script
`timescale 1ns/1ps
`default_nettype none

module i2c_bus_checker (
  input  logic clk,
  input  logic reset,
  input  logic source,
  input  logic scl,
  input  logic sda,
  input  logic tv_in_reset_b,
  input  logic run_done,
  output int   stop_count = 0,
  output int   error_count = 0,
  output int   test_count = 0,
  output int   fail_count = 0,
  output logic final_done = 1'b0
);

  logic       armed = 1'b0;
  logic       prev_scl = 1'b1;
  logic       prev_sda = 1'b1;
  logic       in_trans = 1'b0;
  logic       saw_start = 1'b0;
  logic       last_source = 1'b0;
  logic       bit_seen = 1'b0;
  logic       bit_val = 1'b0;
  logic [7:0] shift_byte = '0;
  int         reset_edges = 0;
  int         hold_left = 0;
  int         bit_pos = 0;
  int         trans_idx = 0;
  int         trans_base = 0;
  int         final_base = 0;
  int         proto_errs = 0;
  int         pending = 0;
  string      cur_name = "";
  logic [7:0] exp_q [$];

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic value_mismatch(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
    $display("FAIL %s expected %02h actual %02h", name, expected, actual);
    error_count++;
  endtask

  task automatic problem(input string text);
    $display("ERROR %s", text);
    error_count++;
  endtask

  task automatic protocol_problem(input string text);
    proto_errs++;
    problem(text);
  endtask

  // One line as each test closes
  task automatic close_test(input string name, input int errs);
    test_count++;
    if (errs == 0)
      $display("test %s ok", name);
    else
    begin
      fail_count++;
      $display("test %s had %0d error(s)", name, errs);
    end
  endtask

  function automatic string test_name(input int idx);
    case (idx)
      0: return "register_block";
      1: return "reg33_write";
      2: return "reg33_pointer";
      3: return "read_address";
      default: return $sformatf("rewrite_%0d", idx - 3);
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Script model
  //////////////////////////////////////////////////

  // Setup transfers split the script on last flags, rewrites replay it up to register 0
  task automatic load_expected(input int idx, input logic src);
    int         pos;
    int         t;
    logic [7:0] b;
    exp_q.delete();
    t = 0;
    for (pos = 0; pos < adv_pkg::SCRIPT_LEN; pos++)
    begin
      if ((idx < 4 && t == idx) || (idx >= 4 && pos <= adv_pkg::REG0_INDEX))
      begin
        b = adv_pkg::INIT_SCRIPT[pos][7:0];
        // s-video sets the input select bits
        if (pos == adv_pkg::REG0_INDEX && src)
          b = b | adv_pkg::SOURCE_MASK;
        exp_q.push_back(b);
      end
      if (adv_pkg::INIT_SCRIPT[pos][8])
        t++;
    end
  endtask

  //////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////

  task automatic start_transaction();
    // First start closes the reset check
    if (!saw_start)
    begin
      if (tv_in_reset_b !== 1'b1)
        value_mismatch("reset_outputs", 8'h01, {7'b0, tv_in_reset_b});
      close_test("reset_outputs", error_count);
      saw_start = 1'b1;
    end
    cur_name   = test_name(trans_idx);
    trans_base = error_count;
    if (trans_idx >= 4)
    begin
      if (pending == 0)
        problem($sformatf("%s appeared with no source change", cur_name));
      else
        pending--;
    end
    load_expected(trans_idx, source);
    in_trans = 1'b1;
    bit_seen = 1'b0;
    bit_pos  = 0;
  endtask

  task automatic end_transaction();
    if (bit_pos != 0)
      protocol_problem($sformatf("%s stopped after a partial byte", cur_name));
    if (exp_q.size() != 0)
      problem($sformatf("%s stopped with %0d byte(s) missing", cur_name, exp_q.size()));
    close_test(cur_name, error_count - trans_base);
    in_trans = 1'b0;
    trans_idx++;
    stop_count <= stop_count + 1;
  endtask

  // Eight data bits, then the acknowledge slot is skipped
  task automatic take_bit(input logic value);
    logic [7:0] expected;
    if (bit_pos < 8)
      shift_byte = {shift_byte[6:0], value};
    if (bit_pos == 7)
    begin
      if (exp_q.size() == 0)
        problem($sformatf("%s sent more bytes than expected", cur_name));
      else
      begin
        expected = exp_q.pop_front();
        if (shift_byte !== expected)
          value_mismatch(cur_name, expected, shift_byte);
      end
    end
    bit_pos = (bit_pos == 8) ? 0 : bit_pos + 1;
  endtask

  always @(posedge clk)
  begin
    if (reset)
    begin
      armed       = 1'b1;
      reset_edges++;
      hold_left   = adv_pkg::RESET_HOLD;
      last_source = source;
      // Outputs settle two edges into reset
      if (reset_edges >= 3 && {scl, sda, tv_in_reset_b} !== 3'b110)
        value_mismatch("reset_outputs", 8'h06, {5'b0, scl, sda, tv_in_reset_b});
    end
    else if (armed && hold_left > 0)
    begin
      // Bus reset still stretched
      hold_left--;
      last_source = source;
      if ({scl, sda, tv_in_reset_b} !== 3'b110)
        value_mismatch("reset_outputs", 8'h06, {5'b0, scl, sda, tv_in_reset_b});
    end
    else if (armed)
    begin
      if (source !== last_source)
      begin
        pending++;
        last_source = source;
      end
      if (prev_scl && scl && prev_sda !== sda)
      begin
        // sda moving under a high scl is only a start or a stop
        if (!sda && !in_trans)
          start_transaction();
        else if (sda && in_trans)
          end_transaction();
        else
          protocol_problem("sda changed while scl was high");
      end
      else if (!prev_scl && scl)
      begin
        bit_val  = sda;
        bit_seen = 1'b1;
      end
      else if (prev_scl && !scl)
      begin
        if (!in_trans)
          protocol_problem("scl pulsed outside a transaction");
        else if (bit_seen)
          take_bit(bit_val);
        bit_seen = 1'b0;
      end
    end
    prev_scl = scl;
    prev_sda = sda;

    // End of run checks
    if (run_done && !final_done)
    begin
      if (!saw_start)
        problem("no start condition was seen on the bus");
      final_base = error_count;
      if (pending != 0)
        problem($sformatf("%0d source change(s) got no rewrite", pending));
      close_test("rewrite_count", error_count - final_base);
      if (in_trans)
        protocol_problem("run ended inside a transaction");
      close_test("bus_protocol", proto_errs);
      final_done <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_adv_config.sv ====
// Testbench top for the decoder setup block, with random input select changes and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_adv_config;

  localparam logic [31:0] LFSR_SEED = 32'd81065;
  // x^32 + x^22 + x^2 + x + 1, Galois form
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam int ROUNDS = 6;
  localparam int INIT_TRANSACTIONS = 4;
  localparam int QUIET_TICKS = 50;

  // Run limit in ticks, 40 ticks bound one byte with its share of start and stop
  localparam longint LIMIT_TICKS = longint'((adv_pkg::SCRIPT_LEN + ROUNDS * 3) * 40
    + adv_pkg::RESET_HOLD / adv_pkg::TICK_DIVIDE + 1 + ROUNDS * 255 + QUIET_TICKS + 200);
  localparam longint LIMIT_NS = LIMIT_TICKS * adv_pkg::TICK_DIVIDE * 100;

  logic        clk;
  logic        reset;
  logic        source;
  logic        run_done;
  logic        scl;
  logic        sda;
  logic        tv_in_reset_b;
  logic        final_done;
  int          stop_count;
  int          error_count;
  int          test_count;
  int          fail_count;
  logic [31:0] lfsr;

  //////////////////////////////////////////////////
  // Clock and random source
  //////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // One shift of the Galois register
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ LFSR_TAPS;
    return state >> 1;
  endfunction

  // Collects count bits, one register step per bit
  task automatic random_bits(input int count, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      value = {value[6:0], lfsr[0]};
      lfsr  = lfsr_step(lfsr);
    end
  endtask

  task automatic wait_for_stops(input int count);
    while (stop_count < count)
      @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // DUT and bus monitor
  //////////////////////////////////////////////////

  adv_config_top u_dut (
    .clk           (clk),
    .reset         (reset),
    .source        (source),
    .tv_in_reset_b (tv_in_reset_b),
    .scl           (scl),
    .sda           (sda)
  );

  i2c_bus_checker u_checker (
    .clk           (clk),
    .reset         (reset),
    .source        (source),
    .scl           (scl),
    .sda           (sda),
    .tv_in_reset_b (tv_in_reset_b),
    .run_done      (run_done),
    .stop_count    (stop_count),
    .error_count   (error_count),
    .test_count    (test_count),
    .fail_count    (fail_count),
    .final_done    (final_done)
  );

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial
  begin
    logic [7:0] gap;
    logic [7:0] flip;
    reset    = 1'b1;
    source   = 1'b0;
    run_done = 1'b0;
    lfsr     = LFSR_SEED;
    // Starting input select, held through the whole script
    random_bits(1, flip);
    @(posedge clk);
    source <= flip[0];
    @(posedge clk);
    @(posedge clk);
    reset <= 1'b0;
    // Register block and the three trailing transfers
    wait_for_stops(INIT_TRANSACTIONS);
    for (int round = 0; round < ROUNDS; round++)
    begin
      random_bits(8, gap);
      repeat (int'(gap) * adv_pkg::TICK_DIVIDE)
        @(posedge clk);
      random_bits(1, flip);
      // A toggle must bring exactly one rewrite
      if (flip[0])
      begin
        source <= ~source;
        wait_for_stops(stop_count + 1);
      end
    end
    // Quiet stretch so a stray transfer still shows up
    repeat (QUIET_TICKS * adv_pkg::TICK_DIVIDE)
      @(posedge clk);
    run_done <= 1'b1;
    while (!final_done)
      @(posedge clk);
    $display("Tests run %0d, failed %0d, errors %0d", test_count, fail_count, error_count);
    if (fail_count == 0 && error_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(LIMIT_NS);
    $display("Watchdog expired after %0d ns with %0d transactions seen", LIMIT_NS, stop_count);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
source/adv_pkg.sv
source/i2c_rate_gen.sv
source/i2c_byte_tx.sv
source/adv_config_seq.sv
source/adv_config_top.sv
bench/i2c_bus_checker.sv
bench/tb_adv_config.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decoder setup testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal --top-module tb_adv_config -f sim.f -o tb_adv_config
out=$(./obj_dir/tb_adv_config)
echo "$out"
if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
